// ==== logic/cam_bist_pkg.sv ====
/*
  Shared types for the CAM BIST engine. CAM_LAT must match the real CAM search
  latency; the output handler pipeline and the controller drain both depend on it.
*/
package cam_bist_pkg;

  // ====================
  // CAM timing
  // ====================
  // Cycles from a search request to valid match lines and read data
  localparam int CAM_LAT = 2;

  // ====================
  // Expected match reference
  // ====================
  // Encoding follows the match-select pins of the array BIST
  typedef enum logic [1:0] {
    MS_ALL_MATCH       = 2'b00,
    MS_SINGLE_MATCH    = 2'b01,
    MS_SINGLE_MISMATCH = 2'b10,
    MS_ALL_MISMATCH    = 2'b11
  } match_sel_e;

  // ====================
  // Controller FSM
  // ====================
  typedef enum logic [2:0] {
    ST_IDLE         = 3'd0,
    ST_WR_BG        = 3'd1,
    ST_ALL_MATCH    = 3'd2,
    ST_ALL_MISMATCH = 3'd3,
    ST_SINGLE       = 3'd4,
    ST_DRAIN        = 3'd5
  } bist_state_e;

endpackage

// ==== logic/cam_bist_ctrl.sv ====
/*
  Phase and address sequencer. Issues exactly one CAM write or search per cycle.
  A start pulse while busy is not queued and is flagged by an assertion.
*/
`timescale 1ns/1ps

module cam_bist_ctrl #(
  parameter int ENTRIES = 16,
  parameter int DWIDTH = 8,
  localparam int AWIDTH = (ENTRIES > 1) ? $clog2(ENTRIES) : 1
) (
  input  logic                     bist_clk,
  input  logic                     rst_n,
  input  logic                     start,
  output logic                     busy,
  output logic                     done,
  output logic                     cm_mode,
  output logic                     cam_we,
  output logic [AWIDTH-1:0]        cam_wr_addr,
  output logic [DWIDTH-1:0]        cam_wr_data,
  output logic                     cam_search,
  output logic [DWIDTH-1:0]        cam_key,
  output logic [AWIDTH-1:0]        search_addr,
  output cam_bist_pkg::match_sel_e match_sel
);

  import cam_bist_pkg::*;

  // Drain covers the last search in flight plus the fail log update
  localparam int DRAIN_WAIT = CAM_LAT + 1;
  localparam int DRAIN_W = $clog2(DRAIN_WAIT + 1);

  bist_state_e          state_q;
  logic [AWIDTH-1:0]    addr_q;
  logic [1:0]           step_q;
  logic [DRAIN_W-1:0]   drain_q;
  logic                 last_addr;

  assign last_addr = (addr_q == AWIDTH'(ENTRIES - 1));

  // ====================
  // Status outputs
  // ====================
  // Busy from the cycle after start through the done pulse
  assign busy    = (state_q != ST_IDLE);
  assign cm_mode = busy;
  assign done    = (state_q == ST_DRAIN) && (drain_q == DRAIN_W'(DRAIN_WAIT));

  // ====================
  // FSM and counters
  // ====================
  always_ff @(posedge bist_clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
      addr_q  <= '0;
      step_q  <= '0;
      drain_q <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (start) begin
            state_q <= ST_WR_BG;
            addr_q  <= '0;
            step_q  <= '0;
          end
        end
        // Background write of all zeros
        ST_WR_BG: begin
          addr_q <= addr_q + 1'b1;
          if (last_addr) begin
            addr_q  <= '0;
            state_q <= ST_ALL_MATCH;
          end
        end
        ST_ALL_MATCH: begin
          addr_q <= addr_q + 1'b1;
          if (last_addr) begin
            addr_q  <= '0;
            state_q <= ST_ALL_MISMATCH;
          end
        end
        ST_ALL_MISMATCH: begin
          addr_q <= addr_q + 1'b1;
          if (last_addr) begin
            addr_q  <= '0;
            step_q  <= '0;
            state_q <= ST_SINGLE;
          end
        end
        // Four steps per entry, address moves after the restore write
        ST_SINGLE: begin
          step_q <= step_q + 1'b1;
          if (step_q == 2'd3) begin
            addr_q <= addr_q + 1'b1;
            if (last_addr) begin
              addr_q  <= '0;
              drain_q <= '0;
              state_q <= ST_DRAIN;
            end
          end
        end
        ST_DRAIN: begin
          drain_q <= drain_q + 1'b1;
          if (done) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // ====================
  // CAM request decode
  // ====================
  assign cam_wr_addr = addr_q;
  assign search_addr = addr_q;

  always_comb begin
    cam_we      = 1'b0;
    cam_search  = 1'b0;
    cam_wr_data = '0;
    cam_key     = '0;
    match_sel   = MS_ALL_MATCH;
    case (state_q)
      ST_WR_BG: cam_we = 1'b1;
      ST_ALL_MATCH: begin
        cam_search = 1'b1;
        match_sel  = MS_ALL_MATCH;
      end
      ST_ALL_MISMATCH: begin
        cam_search = 1'b1;
        cam_key    = '1;
        match_sel  = MS_ALL_MISMATCH;
      end
      ST_SINGLE: begin
        case (step_q)
          // Set the entry under test to ones
          2'd0: begin
            cam_we      = 1'b1;
            cam_wr_data = '1;
          end
          // Zero key hits every entry except the one under test
          2'd1: begin
            cam_search = 1'b1;
            match_sel  = MS_SINGLE_MISMATCH;
          end
          2'd2: begin
            cam_search = 1'b1;
            cam_key    = '1;
            match_sel  = MS_SINGLE_MATCH;
          end
          // Restore the background
          default: cam_we = 1'b1;
        endcase
      end
      default: ;
    endcase
  end

  // ====================
  // Checks
  // ====================
  // Write and search ports share one request slot
  a_one_request: assert property (@(posedge bist_clk) disable iff (!rst_n)
    !(cam_we && cam_search))
    else $error("CAM write and search requested in the same cycle");

  // No restart of a running test
  a_no_start_busy: assert property (@(posedge bist_clk) disable iff (!rst_n)
    busy |-> !start)
    else $error("start pulse while BIST busy, ignored");

endmodule

// ==== logic/cam_bist_outhandler.sv ====
/*
  Expected match-line generation and compare. Assumes match lines and read data
  arrive exactly CAM_LAT cycles after the search; the data mux is combinational.
*/
`timescale 1ns/1ps

module cam_bist_outhandler #(
  parameter int ENTRIES = 16,
  parameter int DWIDTH = 8,
  localparam int AWIDTH = (ENTRIES > 1) ? $clog2(ENTRIES) : 1
) (
  input  logic                     bist_clk,
  input  logic                     rst_n,
  input  logic                     cm_mode,
  input  logic                     cam_search,
  input  logic [AWIDTH-1:0]        search_addr,
  input  cam_bist_pkg::match_sel_e match_sel,
  input  logic [ENTRIES-1:0]       cam_match,
  input  logic [DWIDTH-1:0]        cam_rd_data,
  output logic [DWIDTH-1:0]        rd_data_out,
  output logic [ENTRIES-1:0]       match_ref,
  output logic                     cmp_valid,
  output logic [AWIDTH-1:0]        cmp_addr,
  output cam_bist_pkg::match_sel_e cmp_sel
);

  import cam_bist_pkg::*;

  // Full groups of DWIDTH entries and the leftover entries
  localparam int FOLD = ENTRIES / DWIDTH;
  localparam int REM = ENTRIES % DWIDTH;

  logic [CAM_LAT-1:0]  vld_pipe;
  logic [AWIDTH-1:0]   addr_pipe [CAM_LAT];
  match_sel_e          sel_pipe [CAM_LAT];
  logic [ENTRIES-1:0]  one_hot;
  logic [ENTRIES-1:0]  diff;
  logic [DWIDTH-1:0]   fold;

  // ====================
  // Latency alignment
  // ====================
  always_ff @(posedge bist_clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe[0] <= cam_search;
      for (int s = 1; s < CAM_LAT; s++) begin
        vld_pipe[s] <= vld_pipe[s-1];
      end
    end
  end

  // Address and select only matter when the valid bit is set
  always_ff @(posedge bist_clk) begin
    addr_pipe[0] <= search_addr;
    sel_pipe[0]  <= match_sel;
    for (int s = 1; s < CAM_LAT; s++) begin
      addr_pipe[s] <= addr_pipe[s-1];
      sel_pipe[s]  <= sel_pipe[s-1];
    end
  end

  assign cmp_valid = vld_pipe[CAM_LAT-1];
  assign cmp_addr  = addr_pipe[CAM_LAT-1];
  assign cmp_sel   = sel_pipe[CAM_LAT-1];

  // ====================
  // Expected match lines
  // ====================
  assign one_hot = ENTRIES'(1) << cmp_addr;

  always_comb begin
    case (cmp_sel)
      MS_ALL_MATCH:       match_ref = '1;
      MS_SINGLE_MATCH:    match_ref = one_hot;
      MS_SINGLE_MISMATCH: match_ref = ~one_hot;
      MS_ALL_MISMATCH:    match_ref = '0;
      default:            match_ref = '0;
    endcase
  end

  // Any set bit is a failing match line
  assign diff = match_ref ^ cam_match;

  // ====================
  // Compactor and expander
  // ====================
  // Entry e lands on bit e mod DWIDTH; leftover entries go to the top bits.
  // With fewer entries than bits (FOLD is 0) this pads zeros below the entries
  always_comb begin
    fold = '0;
    for (int e = 0; e < ENTRIES; e++) begin
      if (e < FOLD * DWIDTH) begin
        fold[e % DWIDTH] = fold[e % DWIDTH] | diff[e];
      end else begin
        fold[e - FOLD * DWIDTH + DWIDTH - REM] = fold[e - FOLD * DWIDTH + DWIDTH - REM] | diff[e];
      end
    end
  end

  // Compare result replaces read data while the test runs
  assign rd_data_out = cm_mode ? fold : cam_rd_data;

  // Select pipeline must be filled with a real value by the time a compare is used
  a_sel_known: assert property (@(posedge bist_clk) disable iff (!rst_n)
    cmp_valid |-> !$isunknown(cmp_sel))
    else $error("compare select unknown at compare time");

endmodule

// ==== logic/cam_bist_fail_log.sv ====
/*
  Fail logger. A compare fails on nonzero compacted data; results update one
  cycle after cmp_valid and are cleared by start. The count saturates.
*/
`timescale 1ns/1ps

module cam_bist_fail_log #(
  parameter int ENTRIES = 16,
  parameter int DWIDTH = 8,
  localparam int AWIDTH = (ENTRIES > 1) ? $clog2(ENTRIES) : 1
) (
  input  logic                     bist_clk,
  input  logic                     rst_n,
  input  logic                     start,
  input  logic                     cmp_valid,
  input  logic [AWIDTH-1:0]        cmp_addr,
  input  cam_bist_pkg::match_sel_e cmp_sel,
  input  logic [DWIDTH-1:0]        rd_data_out,
  output logic                     fail,
  output logic [15:0]              fail_count,
  output logic [AWIDTH-1:0]        first_fail_addr,
  output cam_bist_pkg::match_sel_e first_fail_sel
);

  import cam_bist_pkg::*;

  logic cmp_fail;

  // Failing compare
  assign cmp_fail = cmp_valid && (rd_data_out != '0);

  // ====================
  // Fail record
  // ====================
  always_ff @(posedge bist_clk or negedge rst_n) begin
    if (!rst_n) begin
      fail            <= 1'b0;
      fail_count      <= '0;
      first_fail_addr <= '0;
      first_fail_sel  <= MS_ALL_MATCH;
    end else if (start) begin
      // New run starts from a clean log
      fail            <= 1'b0;
      fail_count      <= '0;
      first_fail_addr <= '0;
      first_fail_sel  <= MS_ALL_MATCH;
    end else if (cmp_fail) begin
      fail <= 1'b1;
      // Hold at all ones
      if (fail_count != 16'hffff) begin
        fail_count <= fail_count + 16'd1;
      end
      // Only the first failure is captured
      if (!fail) begin
        first_fail_addr <= cmp_addr;
        first_fail_sel  <= cmp_sel;
      end
    end
  end

endmodule

// ==== logic/cam_bist_top.sv ====
/*
  CAM BIST top. The CAM is external; its match lines and read data must be valid
  CAM_LAT cycles after cam_search. rd_data_out is compare data while busy.
*/
`timescale 1ns/1ps

module cam_bist_top #(
  parameter int ENTRIES = 16,
  parameter int DWIDTH = 8,
  localparam int AWIDTH = (ENTRIES > 1) ? $clog2(ENTRIES) : 1
) (
  input  logic                     bist_clk,
  input  logic                     rst_n,
  input  logic                     start,
  input  logic [ENTRIES-1:0]       cam_match,
  input  logic [DWIDTH-1:0]        cam_rd_data,
  output logic                     busy,
  output logic                     done,
  output logic                     cam_we,
  output logic [AWIDTH-1:0]        cam_wr_addr,
  output logic [DWIDTH-1:0]        cam_wr_data,
  output logic                     cam_search,
  output logic [DWIDTH-1:0]        cam_key,
  output logic [DWIDTH-1:0]        rd_data_out,
  output logic                     fail,
  output logic [15:0]              fail_count,
  output logic [AWIDTH-1:0]        first_fail_addr,
  output cam_bist_pkg::match_sel_e first_fail_sel
);

  import cam_bist_pkg::*;

  // ====================
  // Internal wiring
  // ====================
  logic                cm_mode;
  logic [AWIDTH-1:0]   search_addr;
  match_sel_e          match_sel;
  logic                cmp_valid;
  logic [AWIDTH-1:0]   cmp_addr;
  match_sel_e          cmp_sel;

  // Sequencer
  cam_bist_ctrl #(.ENTRIES(ENTRIES), .DWIDTH(DWIDTH)) u_ctrl (
    .bist_clk    (bist_clk),
    .rst_n       (rst_n),
    .start       (start),
    .busy        (busy),
    .done        (done),
    .cm_mode     (cm_mode),
    .cam_we      (cam_we),
    .cam_wr_addr (cam_wr_addr),
    .cam_wr_data (cam_wr_data),
    .cam_search  (cam_search),
    .cam_key     (cam_key),
    .search_addr (search_addr),
    .match_sel   (match_sel)
  );

  // Compare and read-data mux, expected match lines stay inside the handler
  cam_bist_outhandler #(.ENTRIES(ENTRIES), .DWIDTH(DWIDTH)) u_outhandler (
    .bist_clk    (bist_clk),
    .rst_n       (rst_n),
    .cm_mode     (cm_mode),
    .cam_search  (cam_search),
    .search_addr (search_addr),
    .match_sel   (match_sel),
    .cam_match   (cam_match),
    .cam_rd_data (cam_rd_data),
    .rd_data_out (rd_data_out),
    .match_ref   (),
    .cmp_valid   (cmp_valid),
    .cmp_addr    (cmp_addr),
    .cmp_sel     (cmp_sel)
  );

  // Result capture
  cam_bist_fail_log #(.ENTRIES(ENTRIES), .DWIDTH(DWIDTH)) u_fail_log (
    .bist_clk        (bist_clk),
    .rst_n           (rst_n),
    .start           (start),
    .cmp_valid       (cmp_valid),
    .cmp_addr        (cmp_addr),
    .cmp_sel         (cmp_sel),
    .rd_data_out     (rd_data_out),
    .fail            (fail),
    .fail_count      (fail_count),
    .first_fail_addr (first_fail_addr),
    .first_fail_sel  (first_fail_sel)
  );

endmodule

// ==== test/tb_clk_gen.sv ====
/*
  Clock and reset source for the testbench. Reset is released on a rising edge
  after RESET_CYCLES cycles.
*/
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter real PERIOD_NS = 4.0,
  parameter int RESET_CYCLES = 3
) (
  output logic bist_clk,
  output logic rst_n
);

  initial begin
    bist_clk = 1'b0;
    forever #(PERIOD_NS / 2.0) bist_clk = ~bist_clk;
  end

  // Reset low for the first cycles
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge bist_clk);
    rst_n <= 1'b1;
  end

endmodule

// ==== test/cam_model.sv ====
/*
  Behavioral binary CAM. Match lines arrive CAM_LAT cycles after a search; the
  read path only returns rd_value one cycle later. One match line may be stuck.
*/
`timescale 1ns/1ps

module cam_model #(
  parameter int ENTRIES = 16,
  parameter int DWIDTH = 8,
  localparam int AWIDTH = (ENTRIES > 1) ? $clog2(ENTRIES) : 1
) (
  input  logic                bist_clk,
  input  logic                rst_n,
  input  logic                cam_we,
  input  logic [AWIDTH-1:0]   cam_wr_addr,
  input  logic [DWIDTH-1:0]   cam_wr_data,
  input  logic                cam_search,
  input  logic [DWIDTH-1:0]   cam_key,
  input  logic [1:0]          fault_kind,
  input  logic [AWIDTH-1:0]   fault_entry,
  input  logic [DWIDTH-1:0]   rd_value,
  output logic [ENTRIES-1:0]  cam_match,
  output logic [DWIDTH-1:0]   cam_rd_data
);

  import cam_bist_pkg::*;

  logic [DWIDTH-1:0]   mem [ENTRIES];
  logic [ENTRIES-1:0]  hit;
  logic [ENTRIES-1:0]  match_pipe [CAM_LAT];

  // Raw match lines, all low when no search is issued
  always_comb begin
    for (int e = 0; e < ENTRIES; e++) begin
      hit[e] = cam_search && (mem[e] == cam_key);
    end
  end

  always_ff @(posedge bist_clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int e = 0; e < ENTRIES; e++) begin
        mem[e] <= '0;
      end
      for (int s = 0; s < CAM_LAT; s++) begin
        match_pipe[s] <= '0;
      end
      cam_rd_data <= '0;
    end else begin
      if (cam_we) begin
        mem[cam_wr_addr] <= cam_wr_data;
      end
      match_pipe[0] <= hit;
      for (int s = 1; s < CAM_LAT; s++) begin
        match_pipe[s] <= match_pipe[s-1];
      end
      cam_rd_data <= rd_value;
    end
  end

  // Fault codes: 1 stuck at 0, 2 stuck at 1, anything else fault free
  always_comb begin
    cam_match = match_pipe[CAM_LAT-1];
    if (fault_kind == 2'd1) begin
      cam_match[fault_entry] = 1'b0;
    end else if (fault_kind == 2'd2) begin
      cam_match[fault_entry] = 1'b1;
    end
  end

endmodule

// ==== test/cam_bist_tb.sv ====
/*
  Testbench for cam_bist_top with 16 entries of 8 bits. Runs a fault table of
  stuck match lines plus read-data pass-through while idle.
*/
`timescale 1ns/1ps

module cam_bist_tb;

  import cam_bist_pkg::*;

  localparam int ENTRIES = 16;
  localparam int DWIDTH = 8;
  localparam int AWIDTH = $clog2(ENTRIES);
  localparam int NUM_ROWS = 10;
  localparam int NUM_PASS = 5;
  // Upper bound for one BIST run
  localparam int ROW_CYCLES = 8 * ENTRIES + 20;
  localparam int WATCHDOG_CYCLES = NUM_ROWS * ROW_CYCLES;
  // Fault codes understood by cam_model
  localparam logic [1:0] FK_NONE = 2'd0;
  localparam logic [1:0] FK_STUCK0 = 2'd1;
  localparam logic [1:0] FK_STUCK1 = 2'd2;

  logic                bist_clk;
  logic                rst_n;
  logic                start;
  logic [ENTRIES-1:0]  cam_match;
  logic [DWIDTH-1:0]   cam_rd_data;
  logic                busy;
  logic                done;
  logic                cam_we;
  logic [AWIDTH-1:0]   cam_wr_addr;
  logic [DWIDTH-1:0]   cam_wr_data;
  logic                cam_search;
  logic [DWIDTH-1:0]   cam_key;
  logic [DWIDTH-1:0]   rd_data_out;
  logic                fail;
  logic [15:0]         fail_count;
  logic [AWIDTH-1:0]   first_fail_addr;
  match_sel_e          first_fail_sel;
  logic [1:0]          fault_kind;
  logic [AWIDTH-1:0]   fault_entry;
  logic [DWIDTH-1:0]   rd_value;
  // Search requests seen on the CAM port, aligned to compare time
  logic [CAM_LAT-1:0]  srch_hist = '0;

  // ====================
  // Fault table
  // ====================
  logic [1:0]          row_kind [NUM_ROWS];
  logic [AWIDTH-1:0]   row_entry [NUM_ROWS];
  logic                row_fail [NUM_ROWS];
  logic [15:0]         row_count [NUM_ROWS];
  logic [AWIDTH-1:0]   row_addr [NUM_ROWS];
  match_sel_e          row_sel [NUM_ROWS];
  logic [DWIDTH-1:0]   pass_vals [NUM_PASS];

  int checks = 0;
  int errors = 0;
  int tests = 0;

  tb_clk_gen #(.PERIOD_NS(4.0), .RESET_CYCLES(3)) u_clk_gen (
    .bist_clk (bist_clk),
    .rst_n    (rst_n)
  );

  cam_bist_top #(.ENTRIES(ENTRIES), .DWIDTH(DWIDTH)) DUT (
    .bist_clk        (bist_clk),
    .rst_n           (rst_n),
    .start           (start),
    .cam_match       (cam_match),
    .cam_rd_data     (cam_rd_data),
    .busy            (busy),
    .done            (done),
    .cam_we          (cam_we),
    .cam_wr_addr     (cam_wr_addr),
    .cam_wr_data     (cam_wr_data),
    .cam_search      (cam_search),
    .cam_key         (cam_key),
    .rd_data_out     (rd_data_out),
    .fail            (fail),
    .fail_count      (fail_count),
    .first_fail_addr (first_fail_addr),
    .first_fail_sel  (first_fail_sel)
  );

  cam_model #(.ENTRIES(ENTRIES), .DWIDTH(DWIDTH)) u_cam (
    .bist_clk    (bist_clk),
    .rst_n       (rst_n),
    .cam_we      (cam_we),
    .cam_wr_addr (cam_wr_addr),
    .cam_wr_data (cam_wr_data),
    .cam_search  (cam_search),
    .cam_key     (cam_key),
    .fault_kind  (fault_kind),
    .fault_entry (fault_entry),
    .rd_value    (rd_value),
    .cam_match   (cam_match),
    .cam_rd_data (cam_rd_data)
  );

  always @(posedge bist_clk) begin
    srch_hist <= {srch_hist[CAM_LAT-2:0], cam_search};
  end

  // ====================
  // Compare tasks
  // ====================
  task automatic check_bit(input string name, input logic exp_v, input logic act_v);
    checks++;
    if (act_v !== exp_v) begin
      errors++;
      $display("mismatch at %0t: %s expected %b actual %b", $time, name, exp_v, act_v);
    end
  endtask

  task automatic check_count(input string name, input logic [15:0] exp_v,
                             input logic [15:0] act_v);
    checks++;
    if (act_v !== exp_v) begin
      errors++;
      $display("mismatch at %0t: %s expected %0d actual %0d", $time, name, exp_v, act_v);
    end
  endtask

  task automatic check_addr(input string name, input logic [AWIDTH-1:0] exp_v,
                            input logic [AWIDTH-1:0] act_v);
    checks++;
    if (act_v !== exp_v) begin
      errors++;
      $display("mismatch at %0t: %s expected %0d actual %0d", $time, name, exp_v, act_v);
    end
  endtask

  task automatic check_sel(input string name, input match_sel_e exp_v,
                           input match_sel_e act_v);
    checks++;
    if (act_v !== exp_v) begin
      errors++;
      $display("mismatch at %0t: %s expected %s actual %s", $time, name,
               exp_v.name(), act_v.name());
    end
  endtask

  task automatic check_data(input string name, input logic [DWIDTH-1:0] exp_v,
                            input logic [DWIDTH-1:0] act_v);
    checks++;
    if (act_v !== exp_v) begin
      errors++;
      $display("mismatch at %0t: %s expected 0x%h actual 0x%h", $time, name, exp_v, act_v);
    end
  endtask

  // Expected outcome of one fault, straight from the test sequence:
  // stuck0 fails all ALL_MATCH searches plus ENTRIES-1 + 1 single searches,
  // stuck1 fails all ALL_MISMATCH searches plus 1 + ENTRIES-1 single searches
  task automatic set_row(input int r, input logic [1:0] kind, input logic [AWIDTH-1:0] entry);
    row_kind[r]  = kind;
    row_entry[r] = entry;
    row_fail[r]  = (kind != FK_NONE);
    row_count[r] = (kind == FK_NONE) ? 16'd0 : 16'(2 * ENTRIES);
    row_addr[r]  = '0;
    row_sel[r]   = (kind == FK_STUCK1) ? MS_ALL_MISMATCH : MS_ALL_MATCH;
  endtask

  task automatic load_tables();
    set_row(0, FK_NONE, 4'd0);
    set_row(1, FK_STUCK0, 4'd0);
    set_row(2, FK_STUCK1, 4'd0);
    set_row(3, FK_STUCK0, 4'd5);
    set_row(4, FK_STUCK1, 4'd5);
    set_row(5, FK_STUCK0, 4'd11);
    set_row(6, FK_STUCK1, 4'd11);
    set_row(7, FK_STUCK0, 4'd15);
    set_row(8, FK_STUCK1, 4'd15);
    // Fault free after a faulty run, log must start clean
    set_row(9, FK_NONE, 4'd0);
    pass_vals[0] = 8'h5a;
    pass_vals[1] = 8'ha5;
    pass_vals[2] = 8'h00;
    pass_vals[3] = 8'hff;
    pass_vals[4] = 8'h3c;
  endtask

  function automatic string kind_name(input logic [1:0] kind);
    if (kind == FK_STUCK0) return "stuck0";
    if (kind == FK_STUCK1) return "stuck1";
    return "none";
  endfunction

  // Compacted failure of entry e sits on bit e mod DWIDTH
  function automatic logic [DWIDTH-1:0] fold_bit(input logic [AWIDTH-1:0] e);
    logic [DWIDTH-1:0] v;
    v = '0;
    v[e % DWIDTH] = 1'b1;
    return v;
  endfunction

  // ====================
  // Test sequences
  // ====================
  // Idle read data must pass straight through
  task automatic run_passthrough();
    int err_before;
    err_before = errors;
    tests++;
    for (int i = 0; i < NUM_PASS; i++) begin
      @(posedge bist_clk);
      rd_value <= pass_vals[i];
      @(posedge bist_clk);
      @(negedge bist_clk);
      check_bit("busy", 1'b0, busy);
      check_data("rd_data_out", pass_vals[i], rd_data_out);
    end
    $display("pass-through while idle: %0d errors", errors - err_before);
  endtask

  // Waits for done, checking every compare on the way
  task automatic wait_done(input logic [AWIDTH-1:0] entry, output logic [15:0] hits);
    int cycles;
    logic seen;
    cycles = 0;
    seen = 1'b0;
    hits = '0;
    while (!seen && cycles < ROW_CYCLES) begin
      @(negedge bist_clk);
      if (srch_hist[CAM_LAT-1] && (rd_data_out != '0)) begin
        hits = hits + 16'd1;
        check_data("rd_data_out", fold_bit(entry), rd_data_out);
      end
      seen = done;
      cycles++;
    end
    if (!seen) begin
      errors++;
      $display("error at %0t: done did not arrive within %0d cycles", $time, ROW_CYCLES);
    end
  endtask

  task automatic run_row(input int r);
    int err_before;
    logic [15:0] hits;
    err_before = errors;
    tests++;
    @(posedge bist_clk);
    fault_kind  <= row_kind[r];
    fault_entry <= row_entry[r];
    @(posedge bist_clk);
    start <= 1'b1;
    @(posedge bist_clk);
    start <= 1'b0;
    // The start edge has cleared the log of the previous run
    @(negedge bist_clk);
    check_bit("busy", 1'b1, busy);
    check_bit("fail", 1'b0, fail);
    check_count("fail_count", 16'd0, fail_count);
    wait_done(row_entry[r], hits);
    check_bit("fail", row_fail[r], fail);
    check_count("fail_count", row_count[r], fail_count);
    check_count("compare hits", row_count[r], hits);
    if (row_fail[r]) begin
      check_addr("first_fail_addr", row_addr[r], first_fail_addr);
      check_sel("first_fail_sel", row_sel[r], first_fail_sel);
    end
    // Single-cycle done, then idle
    @(negedge bist_clk);
    check_bit("done", 1'b0, done);
    check_bit("busy", 1'b0, busy);
    $display("row %0d %s entry %0d: %0d errors", r, kind_name(row_kind[r]),
             row_entry[r], errors - err_before);
  endtask

  // ====================
  // Main flow
  // ====================
  initial begin
    start       <= 1'b0;
    fault_kind  <= FK_NONE;
    fault_entry <= '0;
    rd_value    <= '0;
    load_tables();
    @(posedge rst_n);
    @(posedge bist_clk);
    run_passthrough();
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(r);
    end
    run_passthrough();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog sized from the row budget
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge bist_clk);
    $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

// ==== cam_bist.f ====
logic/cam_bist_pkg.sv
logic/cam_bist_ctrl.sv
logic/cam_bist_outhandler.sv
logic/cam_bist_fail_log.sv
logic/cam_bist_top.sv
test/tb_clk_gen.sv
test/cam_model.sv
test/cam_bist_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the CAM BIST testbench with Verilator.
# Exit status is zero only when the run prints the pass message.

cd "$(dirname "$0")" || exit 1

out="$(verilator --binary --timing --assert -j 0 \
         --top-module cam_bist_tb -f cam_bist.f \
       && ./obj_dir/Vcam_bist_tb)" \
  || { echo "$out"; echo "build or simulation did not complete"; exit 1; }

echo "$out"
echo "$out" | grep -q "RESULT: PASS" && exit 0 || exit 1
